// ==== riscv_clint.f ====
+incdir+src
src/riscv_timer_pkg.sv
src/riscv_clint_bus_pkg.sv
src/riscv_timer_irq.sv
src/riscv_clint_regmap.sv
src/riscv_clint_top.sv
verification/riscv_clint_tb.sv

// ==== run_riscv_clint.sh ====
#!/bin/sh
# Build the CLINT testbench with Verilator, run it, then scan the log.
cd "$(dirname "$0")" || exit 1
LOG=riscv_clint_sim.log

verilator --binary --timing --assert -f riscv_clint.f \
  --top-module riscv_clint_tb -o riscv_clint_sim > "$LOG" 2>&1 &&
  ./obj_dir/riscv_clint_sim >> "$LOG" 2>&1 ||
  echo "Build or simulation ended with an error, see $LOG."

grep -q "STATUS: FAIL" "$LOG" && { echo "Simulation failed."; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "Simulation did not complete."; exit 1; }
echo "Simulation passed."
exit 0

// ==== src/riscv_clint_bus_pkg.sv ====
`default_nettype none

`include "riscv_clint_consts.svh"

package riscv_clint_bus_pkg;

  // Byte offset into the CLINT window.
  typedef logic [`RISCV_CLINT_ADDR_W-1:0] bus_addr_t;

  // Full register data word.
  typedef logic [`RISCV_CLINT_DATA_W-1:0] bus_data_t;

  // ******************************************************************
  // One external single-cycle access.
  // wren and rden are strobes, never high together.
  // ******************************************************************
  typedef struct packed {
    logic      wren;
    logic      rden;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

endpackage

`default_nettype wire

// ==== src/riscv_clint_consts.svh ====
`ifndef RISCV_CLINT_CONSTS_SVH
`define RISCV_CLINT_CONSTS_SVH

// Register port geometry.
`define RISCV_CLINT_ADDR_W 16
`define RISCV_CLINT_DATA_W 64

// Byte offsets of the registers for hart 0.
`define RISCV_CLINT_MSIP_OFS     16'h0000
`define RISCV_CLINT_MTIMECMP_OFS 16'h4000
`define RISCV_CLINT_MTIME_OFS    16'hBFF8

// Timer register select codes.
`define RISCV_TIMER_SEL_NONE     2'b00
`define RISCV_TIMER_SEL_MTIME    2'b01
`define RISCV_TIMER_SEL_MTIMECMP 2'b10

`endif

// ==== src/riscv_clint_regmap.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_clint_consts.svh"

module riscv_clint_regmap (
  input  wire                               i_riscv_timer_clk,
  input  wire                               i_riscv_timer_rst,
  input  wire riscv_clint_bus_pkg::bus_req_t i_riscv_timer_bus_req,
  input  wire riscv_timer_pkg::timer_val_t  i_riscv_timer_rdata,
  output riscv_timer_pkg::timer_ctl_t       o_riscv_timer_ctl,
  output riscv_clint_bus_pkg::bus_data_t    o_riscv_timer_rdata,
  output logic                              o_riscv_timer_msip
);

  logic sel_msip;
  logic sel_mtimecmp;
  logic sel_mtime;
  logic sel_timer;

  logic                           msip;
  riscv_clint_bus_pkg::bus_data_t msip_rword;

  // ******************************************************************
  // Address decode, done once for both reads and writes.
  // ******************************************************************
  assign sel_msip     = (i_riscv_timer_bus_req.addr == `RISCV_CLINT_MSIP_OFS);
  assign sel_mtimecmp = (i_riscv_timer_bus_req.addr == `RISCV_CLINT_MTIMECMP_OFS);
  assign sel_mtime    = (i_riscv_timer_bus_req.addr == `RISCV_CLINT_MTIME_OFS);
  assign sel_timer    = sel_mtime || sel_mtimecmp;

  // Timer access only for its own two offsets.
  always_comb
  begin
    o_riscv_timer_ctl.wren   = i_riscv_timer_bus_req.wren && sel_timer;
    o_riscv_timer_ctl.rden   = i_riscv_timer_bus_req.rden && sel_timer;
    o_riscv_timer_ctl.wdata  = i_riscv_timer_bus_req.wdata;
    if (sel_mtime)
    begin
      o_riscv_timer_ctl.regsel = `RISCV_TIMER_SEL_MTIME;
    end
    else if (sel_mtimecmp)
    begin
      o_riscv_timer_ctl.regsel = `RISCV_TIMER_SEL_MTIMECMP;
    end
    else
    begin
      o_riscv_timer_ctl.regsel = `RISCV_TIMER_SEL_NONE;
    end
  end

  // ******************************************************************
  // Software interrupt pending bit.
  // ******************************************************************

  // Only bit 0 of the write word is kept.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin : msip_proc
    if (i_riscv_timer_rst)
    begin
      msip <= 1'b0;
    end
    else if (i_riscv_timer_bus_req.wren && sel_msip)
    begin
      msip <= i_riscv_timer_bus_req.wdata[0];
    end
  end

  assign o_riscv_timer_msip = msip;

  // Zero-extended, and zero outside a read strobe.
  assign msip_rword = {{(`RISCV_CLINT_DATA_W-1){1'b0}},
                       msip && i_riscv_timer_bus_req.rden};

  // ******************************************************************
  // Read return by decoded address.
  // ******************************************************************

  // Timer data is already zero when its rden is low.
  always_comb
  begin
    if (sel_timer)
    begin
      o_riscv_timer_rdata = i_riscv_timer_rdata;
    end
    else if (sel_msip)
    begin
      o_riscv_timer_rdata = msip_rword;
    end
    else
    begin
      o_riscv_timer_rdata = '0;
    end
  end

  // ******************************************************************
  // Assertions.
  // ******************************************************************

  // Bus rule, one strobe at a time.
  a_no_rd_wr : assert property (
    @(posedge i_riscv_timer_clk) disable iff (i_riscv_timer_rst)
    !(i_riscv_timer_bus_req.wren && i_riscv_timer_bus_req.rden)
  );

  // Decoded selects never overlap.
  a_sel_onehot : assert property (
    @(posedge i_riscv_timer_clk) disable iff (i_riscv_timer_rst)
    $onehot0({sel_msip, sel_mtimecmp, sel_mtime})
  );

endmodule

`default_nettype wire

// ==== src/riscv_clint_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_clint_top (
  input  wire                               i_riscv_timer_clk,
  input  wire                               i_riscv_timer_rst,
  input  wire riscv_clint_bus_pkg::bus_req_t i_riscv_timer_bus_req,
  output riscv_clint_bus_pkg::bus_data_t    o_riscv_timer_rdata,
  output riscv_timer_pkg::timer_val_t       o_riscv_timer_time,
  output logic                              o_riscv_timer_irq,
  output logic                              o_riscv_timer_msip
);

  // ******************************************************************
  // Register map to timer link.
  // ******************************************************************
  riscv_timer_pkg::timer_ctl_t timer_ctl;
  riscv_timer_pkg::timer_val_t timer_rdata;

  // Decode, msip and read return.
  riscv_clint_regmap u_regmap (
    .i_riscv_timer_clk     (i_riscv_timer_clk),
    .i_riscv_timer_rst     (i_riscv_timer_rst),
    .i_riscv_timer_bus_req (i_riscv_timer_bus_req),
    .i_riscv_timer_rdata   (timer_rdata),
    .o_riscv_timer_ctl     (timer_ctl),
    .o_riscv_timer_rdata   (o_riscv_timer_rdata),
    .o_riscv_timer_msip    (o_riscv_timer_msip)
  );

  // mtime, mtimecmp and the timer interrupt.
  riscv_timer_irq u_timer (
    .i_riscv_timer_clk   (i_riscv_timer_clk),
    .i_riscv_timer_rst   (i_riscv_timer_rst),
    .i_riscv_timer_ctl   (timer_ctl),
    .o_riscv_timer_rdata (timer_rdata),
    .o_riscv_timer_time  (o_riscv_timer_time),
    .o_riscv_timer_irq   (o_riscv_timer_irq)
  );

endmodule

`default_nettype wire

// ==== src/riscv_timer_irq.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_clint_consts.svh"

module riscv_timer_irq (
  input  wire                         i_riscv_timer_clk,
  input  wire                         i_riscv_timer_rst,
  input  wire riscv_timer_pkg::timer_ctl_t i_riscv_timer_ctl,
  output riscv_timer_pkg::timer_val_t o_riscv_timer_rdata,
  output riscv_timer_pkg::timer_val_t o_riscv_timer_time,
  output logic                        o_riscv_timer_irq
);

  riscv_timer_pkg::timer_val_t mtime;
  riscv_timer_pkg::timer_val_t mtimecmp;

  logic wr_mtime;
  logic wr_mtimecmp;

  // ******************************************************************
  // Write decode from the select code.
  // ******************************************************************
  assign wr_mtime    = i_riscv_timer_ctl.wren &&
                       (i_riscv_timer_ctl.regsel == `RISCV_TIMER_SEL_MTIME);
  assign wr_mtimecmp = i_riscv_timer_ctl.wren &&
                       (i_riscv_timer_ctl.regsel == `RISCV_TIMER_SEL_MTIMECMP);

  // Free-running counter, overwritten by a bus write.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin : mtime_proc
    if (i_riscv_timer_rst)
    begin
      mtime <= '0;
    end
    else if (wr_mtime)
    begin
      mtime <= i_riscv_timer_ctl.wdata;
    end
    else
    begin
      mtime <= mtime + riscv_timer_pkg::timer_val_t'(1);
    end
  end

  // Compare value holds until written.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin : mtimecmp_proc
    if (i_riscv_timer_rst)
    begin
      mtimecmp <= '0;
    end
    else if (wr_mtimecmp)
    begin
      mtimecmp <= i_riscv_timer_ctl.wdata;
    end
  end

  // ******************************************************************
  // Interrupt level and read data.
  // ******************************************************************

  // A zero compare value keeps the timer interrupt off.
  assign o_riscv_timer_irq  = (mtimecmp != '0) && (mtime >= mtimecmp);

  assign o_riscv_timer_time = mtime;

  always_comb
  begin
    o_riscv_timer_rdata = '0;
    if (i_riscv_timer_ctl.rden)
    begin
      case (i_riscv_timer_ctl.regsel)
        `RISCV_TIMER_SEL_MTIME:    o_riscv_timer_rdata = mtime;
        `RISCV_TIMER_SEL_MTIMECMP: o_riscv_timer_rdata = mtimecmp;
        default:                   o_riscv_timer_rdata = '0;
      endcase
    end
  end

  // ******************************************************************
  // Assertions.
  // ******************************************************************

  // A zero compare write disarms the interrupt.
  a_irq_needs_cmp : assert property (
    @(posedge i_riscv_timer_clk) disable iff (i_riscv_timer_rst)
    (wr_mtimecmp && (i_riscv_timer_ctl.wdata == '0)) |=> !o_riscv_timer_irq
  );

  // Counter steps by one unless it is loaded.
  a_mtime_step : assert property (
    @(posedge i_riscv_timer_clk) disable iff (i_riscv_timer_rst)
    !wr_mtime |=> (mtime == $past(mtime) + riscv_timer_pkg::timer_val_t'(1))
  );

endmodule

`default_nettype wire

// ==== src/riscv_timer_pkg.sv ====
`default_nettype none

`include "riscv_clint_consts.svh"

package riscv_timer_pkg;

  // One 64-bit timer quantity.
  typedef logic [`RISCV_CLINT_DATA_W-1:0] timer_val_t;

  // Selects mtime or mtimecmp inside the timer.
  typedef logic [1:0] timer_sel_t;

  // ******************************************************************
  // One access from the register map into the timer block.
  // ******************************************************************
  typedef struct packed {
    logic       wren;
    logic       rden;
    timer_sel_t regsel;
    timer_val_t wdata;
  } timer_ctl_t;

endpackage

`default_nettype wire

// ==== verification/riscv_clint_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_clint_consts.svh"

module riscv_clint_tb;

  localparam logic [1:0] OP_IDLE  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_READ  = 2'd2;

  // One table row, applied for one clock cycle.
  typedef struct packed {
    logic [1:0]                     op;
    riscv_clint_bus_pkg::bus_addr_t ofs;
    riscv_clint_bus_pkg::bus_data_t wdata;
    logic                           exp_irq;
    logic                           exp_msip;
  } stim_t;

  logic                           clk;
  logic                           rst;
  riscv_clint_bus_pkg::bus_req_t  bus_req;
  riscv_clint_bus_pkg::bus_data_t rdata;
  riscv_timer_pkg::timer_val_t    mtime_out;
  logic                           irq;
  logic                           msip;

  stim_t  stim_q[$];
  logic   stim_ready = 1'b0;
  integer seed;

  // Reference model state for the current cycle.
  riscv_timer_pkg::timer_val_t m_mtime;
  riscv_timer_pkg::timer_val_t m_mtimecmp;
  logic                        m_msip;

  riscv_clint_top u_dut (
    .i_riscv_timer_clk     (clk),
    .i_riscv_timer_rst     (rst),
    .i_riscv_timer_bus_req (bus_req),
    .o_riscv_timer_rdata   (rdata),
    .o_riscv_timer_time    (mtime_out),
    .o_riscv_timer_irq     (irq),
    .o_riscv_timer_msip    (msip)
  );

  always #20 clk = ~clk;

  // ******************************************************************
  // Check, table building and model helpers.
  // ******************************************************************
  task automatic check_value(input riscv_clint_bus_pkg::bus_data_t actual,
                             input riscv_clint_bus_pkg::bus_data_t expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("mismatch at time %0t: %s, got 0x%016h, expected 0x%016h",
               $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic add_entry(input logic [1:0] op,
                           input riscv_clint_bus_pkg::bus_addr_t ofs,
                           input riscv_clint_bus_pkg::bus_data_t wdata,
                           input logic exp_irq,
                           input logic exp_msip);
    stim_t ent;
    ent.op       = op;
    ent.ofs      = ofs;
    ent.wdata    = wdata;
    ent.exp_irq  = exp_irq;
    ent.exp_msip = exp_msip;
    stim_q.push_back(ent);
  endtask

  task automatic next_random(output riscv_clint_bus_pkg::bus_data_t val);
    val = {$random(seed), $random(seed)};
  endtask

  task automatic build_stimulus();
    riscv_clint_bus_pkg::bus_data_t rnd;
    // Values right after reset release.
    add_entry(OP_READ, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    // Free-running mtime and random loads.
    for (int i = 0; i < 3; i++)
    begin
      add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    end
    next_random(rnd);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIME_OFS, rnd, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_IDLE, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    next_random(rnd);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIME_OFS, rnd, 1'b0, 1'b0);
    add_entry(OP_IDLE, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_IDLE, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b0);
    // Compare at 110 with mtime loaded to 100.
    add_entry(OP_WRITE, `RISCV_CLINT_MTIME_OFS, 64'd100, 1'b0, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIMECMP_OFS, 64'd110, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      add_entry(OP_IDLE, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b0);
    end
    add_entry(OP_IDLE, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b1, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b1, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIMECMP_OFS, 64'd200, 1'b1, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIMECMP_OFS, 64'd50, 1'b0, 1'b0);
    add_entry(OP_IDLE, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b1, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b1, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b0);
    // Software interrupt, only bit 0 is stored.
    add_entry(OP_WRITE, `RISCV_CLINT_MSIP_OFS, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b0);
    add_entry(OP_READ, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_WRITE, `RISCV_CLINT_MSIP_OFS, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b1);
    add_entry(OP_READ, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MSIP_OFS, 64'd1, 1'b0, 1'b0);
    add_entry(OP_IDLE, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_WRITE, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_READ, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b0);
    // Unmapped offsets leave every register alone.
    add_entry(OP_WRITE, `RISCV_CLINT_MSIP_OFS, 64'd1, 1'b0, 1'b0);
    add_entry(OP_WRITE, `RISCV_CLINT_MTIMECMP_OFS, 64'hFFFF_0000_0000_0000, 1'b0, 1'b1);
    add_entry(OP_WRITE, 16'h0008, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b1);
    add_entry(OP_READ, 16'h0008, 64'd0, 1'b0, 1'b1);
    add_entry(OP_WRITE, 16'hBFF0, 64'd0, 1'b0, 1'b1);
    add_entry(OP_READ, 16'h4008, 64'd0, 1'b0, 1'b1);
    add_entry(OP_READ, `RISCV_CLINT_MTIME_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_READ, `RISCV_CLINT_MTIMECMP_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_READ, `RISCV_CLINT_MSIP_OFS, 64'd0, 1'b0, 1'b1);
    add_entry(OP_IDLE, 16'h0008, 64'd0, 1'b0, 1'b1);
  endtask

  function automatic riscv_clint_bus_pkg::bus_data_t model_rdata(input stim_t ent);
    riscv_clint_bus_pkg::bus_data_t val;
    val = '0;
    // Zero whenever the read strobe is low.
    if (ent.op == OP_READ)
    begin
      case (ent.ofs)
        `RISCV_CLINT_MTIME_OFS:    val = m_mtime;
        `RISCV_CLINT_MTIMECMP_OFS: val = m_mtimecmp;
        `RISCV_CLINT_MSIP_OFS:     val = {63'd0, m_msip};
        default:                   val = '0;
      endcase
    end
    return val;
  endfunction

  function automatic logic model_irq();
    return (m_mtimecmp != '0) && (m_mtime >= m_mtimecmp);
  endfunction

  task automatic apply_entry(input stim_t ent);
    bus_req.wren  = (ent.op == OP_WRITE);
    bus_req.rden  = (ent.op == OP_READ);
    bus_req.addr  = ent.ofs;
    bus_req.wdata = ent.wdata;
  endtask

  task automatic check_entry(input stim_t ent);
    check_value(rdata, model_rdata(ent), "read data");
    check_value(mtime_out, m_mtime, "mtime output");
    check_value({63'd0, irq}, {63'd0, ent.exp_irq}, "irq against table");
    check_value({63'd0, irq}, {63'd0, model_irq()}, "irq against model");
    check_value({63'd0, msip}, {63'd0, ent.exp_msip}, "msip against table");
    check_value({63'd0, msip}, {63'd0, m_msip}, "msip against model");
  endtask

  // State seen in the cycle after this entry's edge.
  task automatic advance_model(input stim_t ent);
    riscv_timer_pkg::timer_val_t next_mtime;
    next_mtime = m_mtime + 64'd1;
    if (ent.op == OP_WRITE)
    begin
      case (ent.ofs)
        `RISCV_CLINT_MTIME_OFS:    next_mtime = ent.wdata;
        `RISCV_CLINT_MTIMECMP_OFS: m_mtimecmp = ent.wdata;
        `RISCV_CLINT_MSIP_OFS:     m_msip = ent.wdata[0];
        default:                   m_msip = m_msip;
      endcase
    end
    m_mtime = next_mtime;
  endtask

  // ******************************************************************
  // Main sequence and watchdog.
  // ******************************************************************
  initial
  begin : main
    clk        = 1'b0;
    rst        = 1'b1;
    bus_req    = '0;
    seed       = 32'h26d7;
    m_mtime    = '0;
    m_mtimecmp = '0;
    m_msip     = 1'b0;
    build_stimulus();
    stim_ready = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < stim_q.size(); i++)
    begin
      apply_entry(stim_q[i]);
      #10;
      check_entry(stim_q[i]);
      advance_model(stim_q[i]);
      @(posedge clk);
      #2;
    end
    bus_req = '0;
    $display("STATUS: PASS");
    $finish;
  end

  initial
  begin : watchdog
    int limit_ns;
    wait (stim_ready);
    limit_ns = (stim_q.size() + 20) * 40;
    #(limit_ns);
    $display("Watchdog timeout: the table did not finish within %0d ns.", limit_ns);
    $display("STATUS: FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire
